// ==== project.f ====
+incdir+include
src/pha_pkg.sv
src/pha_baseline_tracker.sv
src/pha_pulse_analyzer.sv
src/pha_histogram.sv
src/pha_run_control.sv
src/pha_top.sv
testbench/pha_tb_props.sv
testbench/pha_tb.sv

// ==== Bender.yml ====
package:
  name: pha_spectrometer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/pha_pkg.sv
      - src/pha_baseline_tracker.sv
      - src/pha_pulse_analyzer.sv
      - src/pha_histogram.sv
      - src/pha_run_control.sv
      - src/pha_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/pha_tb_props.sv
      - testbench/pha_tb.sv

// ==== testbench/pha_tb.sv ====
`timescale 1ns/1ps
`include "pha_settings.svh"

module pha_tb;

  import pha_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NBINS      = 1 << `PHA_BIN_BITS;
  localparam int BIN_SHIFT  = `PHA_DATA_WIDTH - `PHA_BIN_BITS;
  localparam int SHIFT      = `PHA_BLN_SHIFT;
  localparam int NTESTS     = 6;
  localparam int RUN_LEN [NTESTS] = '{600, 100, 600, 600, 600, 457};

  logic       aclk;
  logic       aresetn;
  logic       sample_valid;
  sample_t    sample_data;
  logic       bln_flag;
  dead_t      dead_time;
  sample_t    min_height;
  sample_t    max_height;
  run_time_t  run_time;
  logic       start;
  bin_addr_t  rd_addr;
  logic       busy;
  logic       done;
  bin_count_t rd_data;

  int      value_errors = 0;
  int      other_errors = 0;
  sample_t level;
  sample_t pulse_q [$];
  int      gap_q [$];    // Idle cycles before each queued sample

  // Reference model state
  sample_t m_d0, m_d1, m_min;
  int      m_cntr, m_acc, model_total;
  logic    m_enbl, m_rising;
  int      model_bins [NBINS];

  pha_top i_pha_top (.*);

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  // ####################################################################
  // Stimulus and model
  // ####################################################################

  task automatic queue_sample(input sample_t s, input bit dense);
    pulse_q.push_back(s);
    gap_q.push_back(dense ? 0 : int'($urandom_range(0, 2)));
  endtask

  task automatic fill_pulse();
    int gap, rise, fall, amp, amp2, i;
    gap  = $urandom_range(2, 6);
    rise = $urandom_range(2, 6);
    fall = $urandom_range(2, 6);
    amp  = $urandom_range(64, 40000);
    amp2 = $urandom_range(64, 20000);
    repeat (gap) queue_sample(level, 1'b0);
    if ($urandom_range(0, 3) == 0)
    begin
      // Two peaks ending two samples apart, sent back to back
      queue_sample(sample_t'(level + amp / 2), 1'b1);
      queue_sample(sample_t'(level + amp), 1'b1);
      queue_sample(sample_t'(level + amp / 2), 1'b1);
      queue_sample(sample_t'(level + amp + amp2), 1'b1);
      queue_sample(level, 1'b1);
    end
    else
    begin
      for (i = 1; i <= rise; i++)
        queue_sample(sample_t'(level + amp * i / rise), 1'b0);      // Leading edge
      for (i = 1; i <= fall; i++)
        queue_sample(sample_t'(level + amp * (fall - i) / fall), 1'b0);
    end
  endtask

  task automatic next_sample(output sample_t s, output int idle);
    if (pulse_q.size() == 0)
      fill_pulse();
    s    = pulse_q.pop_front();
    idle = gap_q.pop_front();
  endtask

  task automatic model_sample(input sample_t s);
    sample_t bln, ref_lvl, height;
    logic    rise_now, dead;
    int      diff;
    rise_now = m_d1 < s;                             // Compared with the sample two back
    dead     = m_cntr < int'(dead_time);
    bln      = sample_t'(m_acc >> SHIFT);
    ref_lvl  = bln_flag ? m_min : bln;
    height   = m_d0 - ref_lvl;
    if (dead)
      m_cntr++;
    if (!dead && !m_rising && rise_now)
    begin
      m_min  = m_d1;
      m_enbl = 1'b1;
    end
    if (m_enbl && m_rising && !rise_now && height > min_height)
    begin
      m_cntr = 0;
      m_enbl = 1'b0;
      if (m_d0 < max_height)
      begin
        model_bins[height >> BIN_SHIFT]++;
        model_total++;
      end
    end
    m_d1     = m_d0;
    m_d0     = s;
    m_rising = rise_now;
    diff     = (int'(s) << SHIFT) - m_acc;
    m_acc    = m_acc + (diff >>> SHIFT);             // Baseline moves 1/16 of the way
  endtask

  function automatic int watchdog_cycles();
    int total, i;
    total = 20;
    for (i = 0; i < NTESTS; i++)
      total += 3 * RUN_LEN[i] + 1030 + 64 + NBINS;   // Gapped samples, clear, readout
    return 2 * total;
  endfunction

  // ####################################################################
  // One run: clear, acquire, readout and compare
  // ####################################################################

  task automatic read_bins(input string name, input bit zero_bins);
    bin_count_t got;
    int         a, expected, total;
    total   = 0;
    rd_addr = '0;
    for (a = 0; a < NBINS; a++)
    begin
      @(negedge aclk);
      got      = rd_data;
      rd_addr  = bin_addr_t'(a + 1);
      expected = zero_bins ? 0 : model_bins[a];
      assert (got == bin_count_t'(expected))
      else
      begin
        value_errors++;
        $display("ERROR %s: bin %0d expected %0d actual %0d", name, a, expected, got);
      end
      total += int'(got);
    end
    expected = zero_bins ? 0 : model_total;
    assert (total == expected)
    else
    begin
      value_errors++;
      $display("ERROR %s: bin total expected %0d actual %0d", name, expected, total);
    end
  endtask

  task automatic run_test(input string name, input logic flag, input int dead, input int lo,
                          input int hi, input int len, input bit zero_bins);
    sample_t s;
    int      n, wait_cnt, idle;
    bln_flag   = flag;
    dead_time  = dead_t'(dead);
    min_height = sample_t'(lo);
    max_height = sample_t'(hi);
    run_time   = run_time_t'(len);
    level      = sample_t'($urandom_range(100, 1100));   // Flat baseline of this run
    pulse_q.delete();
    gap_q.delete();
    foreach (model_bins[i])
      model_bins[i] = 0;
    model_total = 0;
    start = 1'b1;
    @(negedge aclk);
    start = 1'b0;
    repeat (1030) @(negedge aclk);                     // Clear sweep is 1024 cycles
    for (n = 0; n < len; n++)
    begin
      next_sample(s, idle);
      repeat (idle) @(negedge aclk);
      assert (busy && !done)
      else
      begin
        value_errors++;
        $display("ERROR %s: busy/done before sample %0d expected 1/0 actual %b/%b",
                 name, n, busy, done);
      end
      sample_valid = 1'b1;
      sample_data  = s;
      model_sample(s);
      @(negedge aclk);
      sample_valid = 1'b0;
    end
    wait_cnt = 0;
    while (!done && wait_cnt < 16)
    begin
      @(negedge aclk);
      wait_cnt++;
    end
    assert (done)
    else
    begin
      other_errors++;
      $display("%s: done did not rise after the last sample of the run", name);
    end
    assert (!busy)
    else
    begin
      value_errors++;
      $display("ERROR %s: busy after run expected 0 actual %b", name, busy);
    end
    repeat (5)                                         // Samples after the run are ignored
    begin
      next_sample(s, idle);
      sample_valid = 1'b1;
      sample_data  = s;
      @(negedge aclk);
    end
    sample_valid = 1'b0;
    repeat (8) @(negedge aclk);                        // Let the last increment finish
    read_bins(name, zero_bins);
  endtask

  // ####################################################################
  // Main sequence and watchdog
  // ####################################################################

  initial
  begin
    int prop_fails;
    void'($urandom(31));
    aresetn      = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    bln_flag     = 1'b1;
    dead_time    = '0;
    min_height   = '0;
    max_height   = '1;
    run_time     = '0;
    start        = 1'b0;
    rd_addr      = '0;
    m_d0         = '0;
    m_d1         = '0;
    m_min        = '0;
    m_cntr       = 0;
    m_acc        = 0;
    m_enbl       = 1'b0;
    m_rising     = 1'b0;
    repeat (10) @(negedge aclk);
    aresetn = 1'b1;
    repeat (2) @(negedge aclk);
    run_test("spectrum_local_min", 1'b1, 0, 0, 16'hFFFF, RUN_LEN[0], 1'b0);
    run_test("clear_after_run", 1'b1, 0, 16'hFFFF, 16'hFFFF, RUN_LEN[1], 1'b1);
    run_test("height_cuts", 1'b1, 0, 8000, 24000, RUN_LEN[2], 1'b0);
    run_test("dead_time", 1'b1, 40, 0, 16'hFFFF, RUN_LEN[3], 1'b0);
    run_test("baseline_mode", 1'b0, 0, 0, 16'hFFFF, RUN_LEN[4], 1'b0);
    run_test("run_length", 1'b1, 3, 100, 16'hFFFF, RUN_LEN[5], 1'b0);
    prop_fails = i_pha_top.i_props.assert_fails;
    $display("Errors: %0d value, %0d other, %0d assertion",
             value_errors, other_errors, prop_fails);
    if (value_errors == 0 && other_errors == 0 && prop_fails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_cycles() * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete",
             watchdog_cycles());
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== testbench/pha_tb_props.sv ====
`timescale 1ns/1ps

module pha_tb_props
(
  input logic             aclk,
  input logic             aresetn,
  input logic             height_valid,
  input logic             height_ready,
  input pha_pkg::sample_t height_data,
  input logic             clear_en,
  input logic             acq_enable,
  input logic             busy,
  input logic             done
);

  int unsigned assert_fails = 0;  // Read by the testbench at the end

  held_height: assert property (@(posedge aclk) disable iff (!aresetn)
    height_valid && !height_ready |=> height_valid && $stable(height_data))
  else
  begin
    assert_fails++;
    $error("Held height changed or dropped before the histogram took it");
  end

  clear_or_acquire: assert property (@(posedge aclk) disable iff (!aresetn)
    !(clear_en && acq_enable))
  else
  begin
    assert_fails++;
    $error("Clear sweep and acquisition active together");
  end

  done_or_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    !(done && busy))
  else
  begin
    assert_fails++;
    $error("done and busy high together");
  end

endmodule

bind pha_top pha_tb_props i_props
(
  .aclk         (aclk),
  .aresetn      (aresetn),
  .height_valid (height_valid),
  .height_ready (height_ready),
  .height_data  (height_data),
  .clear_en     (clear_en),
  .acq_enable   (acq_enable),
  .busy         (busy),
  .done         (done)
);

// ==== src/pha_top.sv ====
`timescale 1ns/1ps

module pha_top
(
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                sample_valid,
  input  pha_pkg::sample_t    sample_data,
  input  logic                bln_flag,
  input  pha_pkg::dead_t      dead_time,
  input  pha_pkg::sample_t    min_height,
  input  pha_pkg::sample_t    max_height,
  input  pha_pkg::run_time_t  run_time,
  input  logic                start,
  input  pha_pkg::bin_addr_t  rd_addr,
  output logic                busy,
  output logic                done,
  output pha_pkg::bin_count_t rd_data
);

  import pha_pkg::*;

  logic      acq_enable;
  logic      acq_valid;
  logic      clear_en;
  logic      height_valid;
  logic      height_ready;
  bin_addr_t clear_addr;
  sample_t   bln_data;
  sample_t   height_data;

  assign acq_valid = sample_valid && acq_enable;  // Samples outside a run are ignored

  pha_run_control i_run_control (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .start        (start),
    .run_time     (run_time),
    .sample_valid (sample_valid),
    .acq_enable   (acq_enable),
    .clear_en     (clear_en),
    .clear_addr   (clear_addr),
    .busy         (busy),
    .done         (done)
  );

  pha_baseline_tracker i_baseline_tracker (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .acq_valid   (acq_valid),
    .sample_data (sample_data),
    .bln_data    (bln_data)
  );

  pha_pulse_analyzer i_pulse_analyzer (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .acq_valid    (acq_valid),
    .sample_data  (sample_data),
    .bln_flag     (bln_flag),
    .bln_data     (bln_data),
    .dead_time    (dead_time),
    .min_height   (min_height),
    .max_height   (max_height),
    .height_ready (height_ready),
    .height_valid (height_valid),
    .height_data  (height_data)
  );

  pha_histogram i_histogram (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .height_valid (height_valid),
    .height_data  (height_data),
    .clear_en     (clear_en),
    .clear_addr   (clear_addr),
    .rd_addr      (rd_addr),
    .height_ready (height_ready),
    .rd_data      (rd_data)
  );

endmodule

// ==== src/pha_run_control.sv ====
`timescale 1ns/1ps

module pha_run_control
(
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                start,
  input  pha_pkg::run_time_t  run_time,
  input  logic                sample_valid,
  output logic                acq_enable,
  output logic                clear_en,
  output pha_pkg::bin_addr_t  clear_addr,
  output logic                busy,
  output logic                done
);

  import pha_pkg::*;

  run_state_e state_q;
  bin_addr_t  clear_cnt;
  run_time_t  sample_cnt;
  logic       last_sample;

  assign last_sample = sample_valid && (sample_cnt == run_time - 1'b1);

  // ####################################################################
  // Run sequence
  // ####################################################################

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q    <= st_idle;
      clear_cnt  <= '0;
      sample_cnt <= '0;
    end
    else
    begin
      case (state_q)
        st_idle, st_done:
        begin
          if (start)
            state_q <= st_clear;             // Start while busy is ignored
        end
        st_clear:
        begin
          clear_cnt <= clear_cnt + 1'b1;     // Wraps to zero for the next sweep
          if (&clear_cnt)
          begin
            state_q    <= st_run;
            sample_cnt <= '0;
          end
        end
        st_run:
        begin
          if (sample_valid)
            sample_cnt <= sample_cnt + 1'b1;
          if (last_sample)
            state_q <= st_done;              // Final sample is still taken this cycle
        end
        default:
        begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // ####################################################################
  // Outputs
  // ####################################################################

  assign acq_enable = (state_q == st_run);
  assign clear_en   = (state_q == st_clear);
  assign clear_addr = clear_cnt;
  assign busy       = acq_enable || clear_en;
  assign done       = (state_q == st_done);

endmodule

// ==== src/pha_histogram.sv ====
`timescale 1ns/1ps
`include "pha_settings.svh"

module pha_histogram
(
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                height_valid,
  input  pha_pkg::sample_t    height_data,
  input  logic                clear_en,
  input  pha_pkg::bin_addr_t  clear_addr,
  input  pha_pkg::bin_addr_t  rd_addr,
  output logic                height_ready,
  output pha_pkg::bin_count_t rd_data
);

  import pha_pkg::*;

  localparam int unsigned DEPTH = 1 << `PHA_BIN_BITS;
  localparam int unsigned MSB   = `PHA_DATA_WIDTH - 1;

  bin_count_t mem [DEPTH];
  bin_count_t rd_q;
  bin_count_t mem_wdata;
  bin_addr_t  upd_addr;
  bin_addr_t  mem_raddr;
  bin_addr_t  mem_waddr;
  logic       mem_we;
  logic       rd_phase;
  logic       wr_phase;
  logic       take;

  // ####################################################################
  // Increment sequence: accept, read, write back
  // ####################################################################

  assign height_ready = !(rd_phase || wr_phase || clear_en);
  assign take         = height_valid && height_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rd_phase <= 1'b0;
      wr_phase <= 1'b0;
    end
    else
    begin
      rd_phase <= take;
      wr_phase <= rd_phase;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (take)
      upd_addr <= height_data[MSB -: `PHA_BIN_BITS];  // Bin is the top bits of the height
  end

  // ####################################################################
  // Bin memory, one read port and one write port
  // ####################################################################

  assign mem_raddr = rd_phase ? upd_addr : rd_addr;   // Readout only when increment is idle
  assign mem_we    = clear_en || wr_phase;
  assign mem_waddr = clear_en ? clear_addr : upd_addr;
  assign mem_wdata = clear_en ? '0 : ((&rd_q) ? rd_q : rd_q + 1'b1);  // Saturate

  always_ff @(posedge aclk)
  begin
    if (mem_we)
      mem[mem_waddr] <= mem_wdata;
    rd_q <= mem[mem_raddr];
  end

  assign rd_data = rd_q;

endmodule

// ==== src/pha_pulse_analyzer.sv ====
`timescale 1ns/1ps

module pha_pulse_analyzer
(
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             acq_valid,
  input  pha_pkg::sample_t sample_data,
  input  logic             bln_flag,
  input  pha_pkg::sample_t bln_data,
  input  pha_pkg::dead_t   dead_time,
  input  pha_pkg::sample_t min_height,
  input  pha_pkg::sample_t max_height,
  input  logic             height_ready,
  output logic             height_valid,
  output pha_pkg::sample_t height_data
);

  import pha_pkg::*;

  sample_t data_q [2];   // [0] latest sample, [1] the one before
  sample_t data_d [2];
  sample_t min_q;
  sample_t min_d;
  sample_t height_q;
  sample_t height_d;
  dead_t   cntr_q;
  dead_t   cntr_d;
  logic    enbl_q;
  logic    enbl_d;
  logic    rising_q;
  logic    rising_d;
  logic    valid_q;
  logic    valid_d;

  sample_t ref_level;
  sample_t height_calc;
  logic    rising;
  logic    in_dead;
  logic    pass_min;
  logic    pass_max;
  logic    pulse_end;

  // ####################################################################
  // Slope, height and cuts
  // ####################################################################

  assign in_dead     = cntr_q < dead_time;
  assign rising      = data_q[1] < sample_data;          // Slope over two samples
  assign ref_level   = bln_flag ? min_q : bln_data;      // Local minimum or baseline
  assign height_calc = data_q[0] - ref_level;            // data_q[0] is the peak
  assign pass_min    = height_calc > min_height;
  assign pass_max    = data_q[0] < max_height;
  assign pulse_end   = acq_valid && enbl_q && rising_q && !rising && pass_min;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      data_q[0] <= '0;
      data_q[1] <= '0;
      min_q     <= '0;
      cntr_q    <= '0;
      enbl_q    <= 1'b0;
      rising_q  <= 1'b0;
      valid_q   <= 1'b0;
    end
    else
    begin
      data_q[0] <= data_d[0];
      data_q[1] <= data_d[1];
      min_q     <= min_d;
      cntr_q    <= cntr_d;
      enbl_q    <= enbl_d;
      rising_q  <= rising_d;
      valid_q   <= valid_d;
    end
  end

  always_ff @(posedge aclk)
  begin
    height_q <= height_d;
  end

  // ####################################################################
  // Next state
  // ####################################################################

  always_comb
  begin
    data_d   = data_q;
    min_d    = min_q;
    height_d = height_q;
    cntr_d   = cntr_q;
    enbl_d   = enbl_q;
    rising_d = rising_q;
    valid_d  = valid_q;

    if (acq_valid)
    begin
      data_d[0] = sample_data;
      data_d[1] = data_q[0];
      rising_d  = rising;
    end

    if (acq_valid && in_dead)
      cntr_d = cntr_q + 1'b1;

    // Arm at the start of a rise once the dead time is over
    if (acq_valid && !in_dead && !rising_q && rising)
    begin
      min_d  = data_q[1];
      enbl_d = 1'b1;
    end

    if (valid_q && height_ready)
      valid_d = 1'b0;                          // Taken by the histogram

    if (pulse_end)
    begin
      cntr_d = '0;                             // Restart dead time even when above max
      enbl_d = 1'b0;
      if (pass_max)
      begin
        height_d = height_calc;                // Replaces a height still waiting
        valid_d  = 1'b1;
      end
    end
  end

  assign height_valid = valid_q;
  assign height_data  = height_q;

endmodule

// ==== src/pha_baseline_tracker.sv ====
`timescale 1ns/1ps
`include "pha_settings.svh"

module pha_baseline_tracker
(
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             acq_valid,
  input  pha_pkg::sample_t sample_data,
  output pha_pkg::sample_t bln_data
);

  localparam int unsigned DW    = `PHA_DATA_WIDTH;
  localparam int unsigned SHIFT = `PHA_BLN_SHIFT;
  localparam int unsigned ACC_W = DW + SHIFT;

  // ####################################################################
  // Exponential moving average
  // acc holds the average scaled by 2**SHIFT, so the low SHIFT bits
  // keep the fraction that a plain integer average would lose.
  // ####################################################################

  logic        [ACC_W-1:0] acc_q;
  logic signed [ACC_W:0]   diff;
  logic signed [ACC_W:0]   step;

  assign diff = $signed({1'b0, sample_data, {SHIFT{1'b0}}}) - $signed({1'b0, acc_q});
  assign step = diff >>> SHIFT;  // Arithmetic shift keeps the sign of a falling input

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      acc_q <= '0;
    end
    else if (acq_valid)
    begin
      acc_q <= acc_q + step[ACC_W-1:0];  // Two's complement add also moves downward
    end
  end

  assign bln_data = acc_q[ACC_W-1 -: DW];  // Integer part

endmodule

// ==== src/pha_pkg.sv ====
`include "pha_settings.svh"

package pha_pkg;

  typedef logic [`PHA_DATA_WIDTH-1:0]  sample_t;     // Input sample or pulse height
  typedef logic [`PHA_CNTR_WIDTH-1:0]  dead_t;       // Dead time in samples
  typedef logic [`PHA_BIN_BITS-1:0]    bin_addr_t;   // Histogram address
  typedef logic [`PHA_COUNT_WIDTH-1:0] bin_count_t;  // Count of one bin
  typedef logic [`PHA_TIMER_WIDTH-1:0] run_time_t;   // Run length

  // Run sequence of the spectrometer
  typedef enum logic [1:0]
  {
    st_idle  = 2'd0,
    st_clear = 2'd1,
    st_run   = 2'd2,
    st_done  = 2'd3
  } run_state_e;

endpackage

// ==== include/pha_settings.svh ====
`ifndef PHA_SETTINGS_SVH
`define PHA_SETTINGS_SVH

// Sample and pulse height width
`define PHA_DATA_WIDTH  16

// Dead time counter
`define PHA_CNTR_WIDTH  16

// Histogram address bits, 1024 bins
`define PHA_BIN_BITS    10

// One bin count
`define PHA_COUNT_WIDTH 32

// Run length in samples
`define PHA_TIMER_WIDTH 32

// Baseline filter weight is 2**-PHA_BLN_SHIFT
`define PHA_BLN_SHIFT   4

`endif
